/* cache/cache_control.sv */
`default_nettype none

module cache_control (
    input  logic                     clk,
    input  logic                     rst_n,

    // from the datapath
    input  logic                     hit_0,
    input  logic                     hit_1,
    input  logic                     hit_any,
    input  logic                     dirty_out,
    input  cache_ctrl_pkg::way_sel_t lru_out,

    // cpu request
    input  logic                     cpu_read,
    input  logic                     cpu_write,

    // memory response
    input  logic                     mem_resp,

    // datapath controls
    output cache_ctrl_pkg::way_sel_t cacheline_sel,
    output logic                     tag_source_sel,
    output logic                     load,
    output logic                     load_all,
    output logic                     load_lru,
    output cache_ctrl_pkg::way_sel_t lru_in,

    output logic                     cpu_resp,
    output logic                     mem_read,
    output logic                     mem_write
);
    import cache_ctrl_pkg::*;

    ctrl_state_t state;
    ctrl_state_t next_state;
    logic        cpu_req;

    assign cpu_req = cpu_read | cpu_write;

    always_comb begin
        cacheline_sel  = 1'b0;
        tag_source_sel = tag_src_victim;
        load           = 1'b0;
        load_all       = 1'b0;
        load_lru       = 1'b0;
        lru_in         = 1'b0;
        cpu_resp       = 1'b0;
        mem_read       = 1'b0;
        mem_write      = 1'b0;

        case (state)
            idle_hit: begin
                if (cpu_req && hit_any) begin
                    if (hit_0) begin
                        cacheline_sel = 1'b0;
                        lru_in        = 1'b1;  // evict the other way next
                    end else if (hit_1) begin
                        cacheline_sel = 1'b1;
                        lru_in        = 1'b0;
                    end
                    load_lru = 1'b1;
                    cpu_resp = 1'b1;
                    load     = cpu_write;  // merge the word, mark dirty
                end
            end

            write_back: begin
                cacheline_sel  = lru_out;
                tag_source_sel = tag_src_victim;  // address of the line leaving
                mem_write      = 1'b1;
            end

            read_in: begin
                cacheline_sel  = lru_out;
                tag_source_sel = tag_src_cpu;
                load_all       = 1'b1;  // last edge holds the returned line
                mem_read       = 1'b1;
            end

            default: begin
                // write_back_2 and read_in_2 drive nothing
            end
        endcase
    end

    always_comb begin
        next_state = state;

        case (state)
            idle_hit: begin
                if (cpu_req && !hit_any) begin
                    if (dirty_out) begin
                        next_state = write_back;
                    end else begin
                        next_state = read_in;
                    end
                end
            end

            write_back: begin
                if (mem_resp) begin
                    next_state = write_back_2;
                end
            end

            write_back_2: begin
                if (!mem_resp) begin
                    next_state = read_in;
                end
            end

            read_in: begin
                if (mem_resp) begin
                    next_state = read_in_2;
                end
            end

            read_in_2: begin
                if (!mem_resp) begin
                    next_state = idle_hit;  // request then hits
                end
            end

            default: next_state = idle_hit;
        endcase
    end

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            state <= idle_hit;
        end else begin
            state <= next_state;
        end
    end

endmodule

`default_nettype wire

/* cache/cache_line_writer.sv */
`default_nettype none

module cache_line_writer (
    input  cache_ctrl_pkg::way_sel_t                  cacheline_sel,
    input  logic                                      load,
    input  logic                                      load_all,
    input  cache_geometry_pkg::offset_t               offset,
    input  cache_geometry_pkg::word_t                 cpu_wdata,
    input  cache_geometry_pkg::line_t                 mem_rdata,
    input  cache_geometry_pkg::line_t                 sel_line,
    output cache_geometry_pkg::line_t                 line_in,
    output logic [cache_geometry_pkg::num_ways-1:0]   way_load,
    output logic [cache_geometry_pkg::num_ways-1:0]   way_load_all
);
    import cache_geometry_pkg::*;

    // new line contents for the chosen way
    always_comb begin
        if (load_all) begin
            line_in = mem_rdata;  // fill takes the whole memory line
        end else begin
            line_in = sel_line;
            line_in[offset * word_width +: word_width] = cpu_wdata;
        end
    end

    // only the way named by cacheline_sel is written
    always_comb begin
        way_load                    = '0;
        way_load_all                = '0;
        way_load[cacheline_sel]     = load;
        way_load_all[cacheline_sel] = load_all;
    end

endmodule

`default_nettype wire

/* cache/cache_lru.sv */
`default_nettype none

module cache_lru (
    input  logic                       clk,
    input  logic                       rst_n,
    input  cache_geometry_pkg::index_t index,
    input  logic                       load_lru,
    input  cache_ctrl_pkg::way_sel_t   lru_in,
    output cache_ctrl_pkg::way_sel_t   lru_out
);
    import cache_geometry_pkg::*;
    import cache_ctrl_pkg::*;

    // one bit per set, names the next way to evict
    way_sel_t lru_bits [num_sets];

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            lru_bits <= '{default: 1'b0};  // way 0 goes first
        end else if (load_lru) begin
            lru_bits[index] <= lru_in;
        end
    end

    assign lru_out = lru_bits[index];

endmodule

`default_nettype wire

/* cache/cache_way.sv */
`default_nettype none

module cache_way (
    input  logic                       clk,
    input  logic                       rst_n,
    input  cache_geometry_pkg::index_t index,
    input  cache_geometry_pkg::tag_t   tag_in,
    input  logic                       load,      // cpu write into the line
    input  logic                       load_all,  // fill from memory
    input  cache_geometry_pkg::line_t  line_in,
    output logic                       hit,
    output logic                       dirty,
    output cache_geometry_pkg::tag_t   tag_out,
    output cache_geometry_pkg::line_t  line_out
);
    import cache_geometry_pkg::*;

    logic [num_sets-1:0] valid_bits;
    logic [num_sets-1:0] dirty_bits;
    tag_t                tag_arr  [num_sets];
    line_t               data_arr [num_sets];

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            valid_bits <= '0;
        end else if (load_all) begin
            valid_bits[index] <= 1'b1;
        end
    end

    always_ff @(posedge clk) begin
        if (load_all) begin
            dirty_bits[index] <= 1'b0;  // fresh copy of memory
        end else if (load) begin
            dirty_bits[index] <= 1'b1;
        end
    end

    always_ff @(posedge clk) begin
        if (load_all) begin
            tag_arr[index] <= tag_in;
        end
    end

    always_ff @(posedge clk) begin
        if (load || load_all) begin
            data_arr[index] <= line_in;
        end
    end

    // an invalid line never reports hit or dirty
    assign hit      = valid_bits[index] && (tag_arr[index] == tag_in);
    assign dirty    = valid_bits[index] && dirty_bits[index];
    assign tag_out  = tag_arr[index];
    assign line_out = data_arr[index];

endmodule

`default_nettype wire

/* cache/cache_way_select.sv */
`default_nettype none

module cache_way_select (
    input  cache_ctrl_pkg::way_sel_t                                        cacheline_sel,
    input  cache_ctrl_pkg::way_sel_t                                        lru_out,
    input  logic                                                            tag_source_sel,
    input  logic [cache_geometry_pkg::num_ways-1:0]                         way_hit,
    input  logic [cache_geometry_pkg::num_ways-1:0]                         way_dirty,
    input  cache_geometry_pkg::tag_t [cache_geometry_pkg::num_ways-1:0]     way_tag,
    input  cache_geometry_pkg::line_t [cache_geometry_pkg::num_ways-1:0]    way_line,
    input  cache_geometry_pkg::addr_t                                       cpu_address,
    output logic                                                            hit_0,
    output logic                                                            hit_1,
    output logic                                                            hit_any,
    output logic                                                            dirty_out,
    output cache_geometry_pkg::line_t                                       sel_line,
    output cache_geometry_pkg::word_t                                       cpu_rdata,
    output cache_geometry_pkg::addr_t                                       mem_address,
    output cache_geometry_pkg::line_t                                       mem_wdata
);
    import cache_geometry_pkg::*;
    import cache_ctrl_pkg::*;

    tag_t    cpu_tag;
    index_t  cpu_index;
    offset_t cpu_offset;
    tag_t    mem_tag;

    assign cpu_tag    = cpu_address[tag_lsb +: tag_width];
    assign cpu_index  = cpu_address[index_lsb +: index_width];
    assign cpu_offset = cpu_address[offset_lsb +: offset_width];

    assign hit_0   = way_hit[0];
    assign hit_1   = way_hit[1];
    assign hit_any = |way_hit;

    // dirty bit of the way that would be evicted
    assign dirty_out = way_dirty[lru_out];

    assign sel_line  = way_line[cacheline_sel];
    assign cpu_rdata = sel_line[cpu_offset * word_width +: word_width];

    // write-back uses the victim tag, fill uses the requested tag
    assign mem_tag = (tag_source_sel == tag_src_cpu) ? cpu_tag : way_tag[cacheline_sel];

    assign mem_address = {mem_tag, cpu_index, {index_lsb{1'b0}}};  // line aligned
    assign mem_wdata   = sel_line;

endmodule

`default_nettype wire

/* common/cache_ctrl_pkg.sv */
`default_nettype none

package cache_ctrl_pkg;

    typedef enum logic [2:0] {
        idle_hit,      // serve hits, detect misses
        write_back,    // dirty victim out to memory
        write_back_2,  // wait for mem_resp to drop
        read_in,       // fill line from memory
        read_in_2      // wait for mem_resp to drop
    } ctrl_state_t;

    // names one of the two ways
    typedef logic way_sel_t;

    // tag_source_sel encoding for the memory address
    localparam logic tag_src_victim = 1'b0;  // tag stored in the selected way
    localparam logic tag_src_cpu    = 1'b1;  // tag of the cpu request

endpackage

`default_nettype wire

/* common/cache_geometry_pkg.sv */
`default_nettype none

package cache_geometry_pkg;

    localparam int addr_width     = 16;
    localparam int word_width     = 32;
    localparam int words_per_line = 4;
    localparam int line_width     = word_width * words_per_line;
    localparam int num_sets       = 8;
    localparam int num_ways       = 2;  // the controller hit logic is two-way

    // byte address layout: tag | index | word offset | byte
    localparam int offset_width   = $clog2(words_per_line);
    localparam int index_width    = $clog2(num_sets);
    localparam int offset_lsb     = 2;  // byte bits inside a word are ignored
    localparam int index_lsb      = offset_lsb + offset_width;
    localparam int tag_lsb        = index_lsb + index_width;
    localparam int tag_width      = addr_width - tag_lsb;

    typedef logic [addr_width-1:0]   addr_t;
    typedef logic [tag_width-1:0]    tag_t;
    typedef logic [index_width-1:0]  index_t;
    typedef logic [offset_width-1:0] offset_t;
    typedef logic [word_width-1:0]   word_t;
    typedef logic [line_width-1:0]   line_t;  // word 0 in the low bits

endpackage

`default_nettype wire

/* hw/cache_top.sv */
`default_nettype none

module cache_top (
    input  logic                      clk,
    input  logic                      rst_n,

    // cpu port
    input  logic                      cpu_read,
    input  logic                      cpu_write,
    input  cache_geometry_pkg::addr_t cpu_address,
    input  cache_geometry_pkg::word_t cpu_wdata,
    output logic                      cpu_resp,
    output cache_geometry_pkg::word_t cpu_rdata,

    // line-wide memory port
    input  logic                      mem_resp,
    input  cache_geometry_pkg::line_t mem_rdata,
    output logic                      mem_read,
    output logic                      mem_write,
    output cache_geometry_pkg::addr_t mem_address,
    output cache_geometry_pkg::line_t mem_wdata
);
    import cache_geometry_pkg::*;
    import cache_ctrl_pkg::*;

    tag_t    cpu_tag;
    index_t  cpu_index;
    offset_t cpu_offset;

    logic     hit_0;
    logic     hit_1;
    logic     hit_any;
    logic     dirty_out;
    way_sel_t lru_out;
    way_sel_t cacheline_sel;
    logic     tag_source_sel;
    logic     load;
    logic     load_all;
    logic     load_lru;
    way_sel_t lru_in;

    line_t                line_in;
    line_t                sel_line;
    logic  [num_ways-1:0] way_load;
    logic  [num_ways-1:0] way_load_all;
    logic  [num_ways-1:0] way_hit;
    logic  [num_ways-1:0] way_dirty;
    tag_t  [num_ways-1:0] way_tag;
    line_t [num_ways-1:0] way_line;

    assign cpu_tag    = cpu_address[tag_lsb +: tag_width];
    assign cpu_index  = cpu_address[index_lsb +: index_width];
    assign cpu_offset = cpu_address[offset_lsb +: offset_width];

    cache_control control_i (
        .clk            (clk),
        .rst_n          (rst_n),
        .hit_0          (hit_0),
        .hit_1          (hit_1),
        .hit_any        (hit_any),
        .dirty_out      (dirty_out),
        .lru_out        (lru_out),
        .cpu_read       (cpu_read),
        .cpu_write      (cpu_write),
        .mem_resp       (mem_resp),
        .cacheline_sel  (cacheline_sel),
        .tag_source_sel (tag_source_sel),
        .load           (load),
        .load_all       (load_all),
        .load_lru       (load_lru),
        .lru_in         (lru_in),
        .cpu_resp       (cpu_resp),
        .mem_read       (mem_read),
        .mem_write      (mem_write)
    );

    cache_lru lru_i (
        .clk      (clk),
        .rst_n    (rst_n),
        .index    (cpu_index),
        .load_lru (load_lru),
        .lru_in   (lru_in),
        .lru_out  (lru_out)
    );

    cache_line_writer writer_i (
        .cacheline_sel (cacheline_sel),
        .load          (load),
        .load_all      (load_all),
        .offset        (cpu_offset),
        .cpu_wdata     (cpu_wdata),
        .mem_rdata     (mem_rdata),
        .sel_line      (sel_line),
        .line_in       (line_in),
        .way_load      (way_load),
        .way_load_all  (way_load_all)
    );

    for (genvar w = 0; w < num_ways; w++) begin : g_way
        cache_way way_i (
            .clk      (clk),
            .rst_n    (rst_n),
            .index    (cpu_index),
            .tag_in   (cpu_tag),  // fills always store the requested tag
            .load     (way_load[w]),
            .load_all (way_load_all[w]),
            .line_in  (line_in),
            .hit      (way_hit[w]),
            .dirty    (way_dirty[w]),
            .tag_out  (way_tag[w]),
            .line_out (way_line[w])
        );
    end

    cache_way_select select_i (
        .cacheline_sel  (cacheline_sel),
        .lru_out        (lru_out),
        .tag_source_sel (tag_source_sel),
        .way_hit        (way_hit),
        .way_dirty      (way_dirty),
        .way_tag        (way_tag),
        .way_line       (way_line),
        .cpu_address    (cpu_address),
        .hit_0          (hit_0),
        .hit_1          (hit_1),
        .hit_any        (hit_any),
        .dirty_out      (dirty_out),
        .sel_line       (sel_line),
        .cpu_rdata      (cpu_rdata),
        .mem_address    (mem_address),
        .mem_wdata      (mem_wdata)
    );

endmodule

`default_nettype wire

/* verif/cache_asserts.sv */
`default_nettype none

module cache_asserts (
    input logic                      clk,
    input logic                      rst_n,
    input logic                      cpu_read,
    input logic                      cpu_write,
    input logic                      cpu_resp,
    input logic                      mem_read,
    input logic                      mem_write,
    input cache_geometry_pkg::addr_t mem_address
);
    int fail_count = 0;  // failed assertions so far

    strobes_exclusive: assert property (@(posedge clk) disable iff (!rst_n)
        !(mem_read && mem_write))
        else begin $error("mem_read and mem_write high together"); fail_count++; end

    resp_without_strobe: assert property (@(posedge clk) disable iff (!rst_n)
        !(cpu_resp && (mem_read || mem_write)))
        else begin $error("cpu_resp during a memory strobe"); fail_count++; end

    resp_needs_request: assert property (@(posedge clk) disable iff (!rst_n)
        cpu_resp |-> (cpu_read || cpu_write))
        else begin $error("cpu_resp without a request"); fail_count++; end

    // address held for the whole strobe
    address_stable: assert property (@(posedge clk) disable iff (!rst_n)
        ((mem_read && $past(mem_read)) || (mem_write && $past(mem_write)))
            |-> $stable(mem_address))
        else begin $error("mem_address changed during a strobe"); fail_count++; end

endmodule

bind cache_top cache_asserts asserts_i (.*);

`default_nettype wire

/* verif/cache_tb.sv */
`default_nettype none

module cache_tb;
    import cache_geometry_pkg::*;

    localparam int resp_timeout = 100;  // cycles allowed per cpu request

    logic  clk = 1'b0;
    logic  rst_n;
    logic  cpu_read;
    logic  cpu_write;
    addr_t cpu_address;
    word_t cpu_wdata;
    logic  cpu_resp;
    word_t cpu_rdata;
    logic  mem_resp = 1'b0;
    line_t mem_rdata = '0;
    logic  mem_read;
    logic  mem_write;
    addr_t mem_address;
    line_t mem_wdata;

    logic [31:0] rng = 32'he51be16c;
    line_t       mem [4096];
    word_t       shadow [16384];  // expected value of every word
    int          mem_delay = 0;
    int          read_count = 0;
    int          write_count = 0;
    addr_t       last_wb_address = '0;
    int          snap_reads;
    int          snap_writes;
    int          last_latency;

    always #2 clk = ~clk;

    cache_top dut_i (.*);

    function automatic logic [31:0] xorshift();
        rng = rng ^ (rng << 13);
        rng = rng ^ (rng >> 17);
        rng = rng ^ (rng << 5);
        return rng;
    endfunction

    function automatic addr_t make_addr(input logic [8:0] tag, input logic [2:0] index,
                                        input logic [1:0] word);
        return {tag, index, word, 2'b00};
    endfunction

    // line memory, answers each strobe after 1 to 4 cycles
    always @(posedge clk) begin
        #1;
        if (!rst_n) begin
            mem_resp  = 1'b0;
            mem_delay = 0;
        end else if (mem_resp) begin
            if (!mem_read && !mem_write) begin
                mem_resp = 1'b0;  // second phase done
            end
        end else if (mem_read || mem_write) begin
            if (mem_delay == 0) begin
                mem_delay = 1 + int'(xorshift() % 4);
            end
            mem_delay = mem_delay - 1;
            if (mem_delay == 0) begin
                if (mem_write) begin
                    mem[mem_address[15:4]] = mem_wdata;
                    write_count++;
                    last_wb_address = mem_address;
                end else begin
                    mem_rdata = mem[mem_address[15:4]];
                    read_count++;
                end
                mem_resp = 1'b1;
            end
        end
    end

    task automatic check_equal(input string name, input logic [127:0] actual,
                               input logic [127:0] expected);
        if (actual !== expected) begin
            $display("ERROR time %0t: %s = %0h, expected %0h", $time, name, actual, expected);
            $display("TEST FAILED");
            $fatal(1, "value mismatch");
        end
    endtask

    // one cpu request, held until cpu_resp, read data checked against the shadow
    task automatic access(input logic wr, input addr_t addr, input word_t data);
        int waited;
        waited      = 0;
        cpu_read    = !wr;
        cpu_write   = wr;
        cpu_address = addr;
        cpu_wdata   = data;
        @(negedge clk);
        while (!cpu_resp) begin
            waited++;
            if (waited > resp_timeout) begin
                $display("timeout: cpu_resp never came for the %s at address %h",
                         wr ? "write" : "read", addr);
                $display("TEST FAILED");
                $fatal(1, "cpu_resp timeout");
            end
            @(negedge clk);
        end
        last_latency = waited;
        if (wr) begin
            shadow[addr[15:2]] = data;
        end else begin
            check_equal("cpu_rdata", cpu_rdata, shadow[addr[15:2]]);
        end
        @(posedge clk);
        #1;
        cpu_read  = 1'b0;
        cpu_write = 1'b0;
    endtask

    task automatic save_counts();
        snap_reads  = read_count;
        snap_writes = write_count;
    endtask

    task automatic check_traffic(input int reads, input int writes);
        check_equal("mem read count", read_count - snap_reads, reads);
        check_equal("mem write count", write_count - snap_writes, writes);
    endtask

    task automatic reset_quiet();
        repeat (5) begin
            @(negedge clk);
            check_equal("cpu_resp", cpu_resp, 1'b0);
            check_equal("mem_read", mem_read, 1'b0);
            check_equal("mem_write", mem_write, 1'b0);
        end
        @(posedge clk);
        #1;
    endtask

    task automatic read_miss_then_hit();
        save_counts();
        access(1'b0, make_addr(9'h011, 3'd1, 2'd2), '0);
        check_equal("read miss latency", last_latency > 0, 1'b1);
        check_traffic(1, 0);
        save_counts();
        access(1'b0, make_addr(9'h011, 3'd1, 2'd2), '0);
        check_equal("read hit latency", last_latency, 0);
        check_traffic(0, 0);
    endtask

    task automatic write_hit();
        save_counts();
        access(1'b1, make_addr(9'h011, 3'd1, 2'd2), 32'hcafe_0001);
        check_equal("write hit latency", last_latency, 0);
        for (int w = 0; w < 4; w++) begin
            access(1'b0, make_addr(9'h011, 3'd1, w[1:0]), '0);  // other words unchanged
            check_equal("read after write latency", last_latency, 0);
        end
        check_traffic(0, 0);
    endtask

    task automatic lru_replace();
        access(1'b0, make_addr(9'h020, 3'd2, 2'd0), '0);
        access(1'b0, make_addr(9'h021, 3'd2, 2'd1), '0);
        access(1'b0, make_addr(9'h020, 3'd2, 2'd3), '0);
        check_equal("line A hit latency", last_latency, 0);
        save_counts();
        access(1'b0, make_addr(9'h022, 3'd2, 2'd2), '0);  // replaces B, which is clean
        check_traffic(1, 0);
        access(1'b0, make_addr(9'h020, 3'd2, 2'd1), '0);
        check_equal("line A still cached", last_latency, 0);
        access(1'b0, make_addr(9'h021, 3'd2, 2'd1), '0);
        check_equal("line B evicted", last_latency > 0, 1'b1);
    endtask

    task automatic dirty_evict();
        access(1'b1, make_addr(9'h030, 3'd3, 2'd1), 32'h5a5a_1234);
        access(1'b0, make_addr(9'h031, 3'd3, 2'd0), '0);
        save_counts();
        access(1'b0, make_addr(9'h032, 3'd3, 2'd0), '0);  // evicts dirty A
        check_traffic(1, 1);
        check_equal("write-back address", last_wb_address, make_addr(9'h030, 3'd3, 2'd0));
        check_equal("written-back word", mem[make_addr(9'h030, 3'd3, 2'd0) >> 4][63:32],
                    32'h5a5a_1234);
        access(1'b0, make_addr(9'h030, 3'd3, 2'd1), '0);
        check_equal("line A refetched", last_latency > 0, 1'b1);
    endtask

    task automatic random_mix();
        logic [31:0] r;
        for (int i = 0; i < 200; i++) begin
            r = xorshift();
            // 8 tags, 2 sets, 4 words gives 64 addresses
            access(r[6], make_addr(9'h040 + r[2:0], 3'd4 + r[3], r[5:4]), xorshift());
        end
    endtask

    initial begin
        rst_n       = 1'b0;
        cpu_read    = 1'b0;
        cpu_write   = 1'b0;
        cpu_address = '0;
        cpu_wdata   = '0;
        for (int i = 0; i < 4096; i++) begin
            mem[i] = {xorshift(), xorshift(), xorshift(), xorshift()};
        end
        for (int w = 0; w < 16384; w++) begin
            shadow[w] = mem[w >> 2][(w % 4) * 32 +: 32];
        end
        repeat (10) @(posedge clk);
        #1;
        rst_n = 1'b1;

        reset_quiet();
        read_miss_then_hit();
        write_hit();
        lru_replace();
        dirty_evict();
        random_mix();

        if (dut_i.asserts_i.fail_count == 0) begin
            $display("TEST OK");
            $finish;
        end else begin
            $display("%0d assertion failures in the strobe checks", dut_i.asserts_i.fail_count);
            $display("TEST FAILED");
            $fatal(1, "assertion failures");
        end
    end

endmodule

`default_nettype wire

/* verilog.f */
common/cache_geometry_pkg.sv
common/cache_ctrl_pkg.sv
cache/cache_control.sv
cache/cache_way.sv
cache/cache_line_writer.sv
cache/cache_way_select.sv
cache/cache_lru.sv
hw/cache_top.sv
verif/cache_asserts.sv
verif/cache_tb.sv
